//--- logic/wdog_pkg.sv
`default_nettype none

package wdog_pkg;

  // AXI4-Lite bus geometry
  localparam int axil_addr_width_gp = 32;
  localparam int axil_data_width_gp = 32;
  localparam int axil_strb_width_gp = axil_data_width_gp / 8;

  // Width of a node id on the tag link
  localparam int tag_node_width_gp = 4;

  // Write address channel payload
  typedef struct packed {
    logic [axil_addr_width_gp-1:0] addr;
    logic [2:0]                    prot;
  } axil_aw_s;

  // Write data channel payload
  typedef struct packed {
    logic [axil_data_width_gp-1:0] data;
    logic [axil_strb_width_gp-1:0] strb;
  } axil_w_s;

  // Response codes on B
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } axil_resp_e;

  // Bits after the start bit, node id MSB first, then data
  typedef struct packed {
    logic [tag_node_width_gp-1:0] node_id;
    logic                         data;
  } tag_frame_s;

endpackage

`default_nettype wire

//--- logic/tag_serial_rx.sv
`default_nettype none

module tag_serial_rx
  #(parameter logic [wdog_pkg::tag_node_width_gp-1:0] tag_node_id_p = '0)
  (input  wire logic tag_clk_i,
   input  wire logic arst_n_i,
   input  wire logic tag_data_i,
   output logic      tag_toggle_o,
   output logic      tag_data_o
  );

  import wdog_pkg::*;

  localparam int frame_bits_lp = $bits(tag_frame_s);
  localparam int cnt_width_lp  = $clog2(frame_bits_lp);

  typedef enum logic {
    idle_s,
    shift_s
  } state_e;

  state_e                  state_r;
  logic [cnt_width_lp-1:0] bit_cnt_r;
  tag_frame_s              frame_r;
  tag_frame_s              frame_n;
  logic                    frame_done;
  logic                    node_hit;

  // Shift the current bit in at the LSB end
  assign frame_n = {frame_r[frame_bits_lp-2:0], tag_data_i};

  // Last bit of the frame is on the line
  assign frame_done = (state_r == shift_s) &&
                      (bit_cnt_r == cnt_width_lp'(frame_bits_lp - 1));
  assign node_hit   = frame_done && (frame_n.node_id == tag_node_id_p);

  always_ff @(posedge tag_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= idle_s;
      bit_cnt_r <= '0;
    end
    else
    begin
      case (state_r)
        idle_s:
        begin
          // A high bit on the idle line starts a frame
          if (tag_data_i)
          begin
            state_r   <= shift_s;
            bit_cnt_r <= '0;
          end
        end
        default:
        begin
          if (frame_done)
            state_r <= idle_s;
          else
            bit_cnt_r <= bit_cnt_r + 1'b1;
        end
      endcase
    end
  end

  // Frame bits collected while shifting
  always_ff @(posedge tag_clk_i)
  begin
    if (state_r == shift_s)
      frame_r <= frame_n;
  end

  // Data and toggle move on the same edge
  always_ff @(posedge tag_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tag_toggle_o <= 1'b0;
      tag_data_o   <= 1'b0;
    end
    else if (node_hit)
    begin
      tag_toggle_o <= ~tag_toggle_o;
      tag_data_o   <= frame_n.data;
    end
  end

endmodule

`default_nettype wire

//--- logic/tag_client_sync.sv
`default_nettype none

module tag_client_sync
  (input  wire logic clk_i,
   input  wire logic arst_n_i,
   input  wire logic tag_toggle_i,
   input  wire logic tag_data_i,
   output logic      core_reset_o
  );

  logic [1:0] toggle_sync_r;
  logic       toggle_seen_r;
  logic       toggle_edge;

  // Toggle changed since the last clk_i cycle
  assign toggle_edge = toggle_sync_r[1] ^ toggle_seen_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      toggle_sync_r <= '0;
      toggle_seen_r <= 1'b0;
    end
    else
    begin
      toggle_sync_r <= {toggle_sync_r[0], tag_toggle_i};
      toggle_seen_r <= toggle_sync_r[1];
    end
  end

  // Tag data is stable long before the toggle edge arrives here
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      core_reset_o <= 1'b0;
    else if (toggle_edge)
      core_reset_o <= tag_data_i;
  end

endmodule

`default_nettype wire

//--- logic/kick_timer.sv
`default_nettype none

module kick_timer
  #(parameter int watchdog_period_p = 40)
  (input  wire logic clk_i,
   input  wire logic arst_n_i,
   input  wire logic clear_i,
   output logic      kick_v_o,
   input  wire logic kick_ready_i
  );

  localparam int cnt_width_lp = (watchdog_period_p > 1) ? $clog2(watchdog_period_p) : 1;
  localparam logic [cnt_width_lp-1:0] cnt_max_lp = cnt_width_lp'(watchdog_period_p - 1);

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    cnt_advance;

  // Kick is due at the start of each period
  assign kick_v_o = (cnt_r == '0);

  // Stall at zero until the writer takes the kick
  assign cnt_advance = ~kick_v_o | kick_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cnt_r <= '0;
    else if (clear_i)
      cnt_r <= '0;
    else if (cnt_advance)
    begin
      if (cnt_r == cnt_max_lp)
        cnt_r <= '0;
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/axil_kick_writer.sv
`default_nettype none

module axil_kick_writer
  #(parameter logic [wdog_pkg::axil_addr_width_gp-1:0] kick_addr_p = '0,
    parameter logic [wdog_pkg::axil_data_width_gp-1:0] kick_data_p = '0
  )
  (input  wire logic                  clk_i,
   input  wire logic                  arst_n_i,
   input  wire logic                  clear_i,

   input  wire logic                  kick_v_i,
   output logic                       kick_ready_o,

   // Write address channel
   output wdog_pkg::axil_aw_s         m_axil_aw_o,
   output logic                       m_axil_awvalid_o,
   input  wire logic                  m_axil_awready_i,

   // Write data channel
   output wdog_pkg::axil_w_s          m_axil_w_o,
   output logic                       m_axil_wvalid_o,
   input  wire logic                  m_axil_wready_i,

   // Write response channel
   input  wire wdog_pkg::axil_resp_e  m_axil_bresp_i,
   input  wire logic                  m_axil_bvalid_i,
   output logic                       m_axil_bready_o
  );

  import wdog_pkg::*;

  logic busy_r;
  logic aw_pend_r;
  logic w_pend_r;
  logic kick_accept;
  logic aw_done;
  logic w_done;
  logic b_done;

  // Fixed payload on both channels
  always_comb
  begin
    m_axil_aw_o.addr = kick_addr_p;
    m_axil_aw_o.prot = 3'b000;
    m_axil_w_o.data  = kick_data_p;
    m_axil_w_o.strb  = {axil_strb_width_gp{1'b1}};
  end

  // Only one write in flight
  assign kick_ready_o = ~busy_r;
  assign kick_accept  = kick_v_i & ~busy_r;

  assign m_axil_awvalid_o = aw_pend_r;
  assign m_axil_wvalid_o  = w_pend_r;

  // Wait for B only once both AW and W are through
  assign m_axil_bready_o = busy_r & ~aw_pend_r & ~w_pend_r;

  assign aw_done = aw_pend_r & m_axil_awready_i;
  assign w_done  = w_pend_r & m_axil_wready_i;
  assign b_done  = m_axil_bready_o & m_axil_bvalid_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r    <= 1'b0;
      aw_pend_r <= 1'b0;
      w_pend_r  <= 1'b0;
    end
    else if (clear_i)
    begin
      // Any write in flight is dropped
      busy_r    <= 1'b0;
      aw_pend_r <= 1'b0;
      w_pend_r  <= 1'b0;
    end
    else if (kick_accept)
    begin
      busy_r    <= 1'b1;
      aw_pend_r <= 1'b1;
      w_pend_r  <= 1'b1;
    end
    else
    begin
      // AW and W may finish in either order
      if (aw_done)
        aw_pend_r <= 1'b0;
      if (w_done)
        w_pend_r <= 1'b0;
      if (b_done)
        busy_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/axil_watchdog.sv
`default_nettype none

module axil_watchdog
  #(parameter int watchdog_period_p = 25000000,
    parameter logic [wdog_pkg::axil_addr_width_gp-1:0] kick_addr_p = 32'h0010_3000,
    parameter logic [wdog_pkg::axil_data_width_gp-1:0] kick_data_p = 32'h0000_0001,
    parameter logic [wdog_pkg::tag_node_width_gp-1:0]  tag_node_id_p = '0
  )
  (input  wire logic                  clk_i,
   input  wire logic                  arst_n_i,

   // Serial tag link
   input  wire logic                  tag_clk_i,
   input  wire logic                  tag_data_i,

   // AXI4-Lite write master
   output wdog_pkg::axil_aw_s         m_axil_aw_o,
   output logic                       m_axil_awvalid_o,
   input  wire logic                  m_axil_awready_i,

   output wdog_pkg::axil_w_s          m_axil_w_o,
   output logic                       m_axil_wvalid_o,
   input  wire logic                  m_axil_wready_i,

   input  wire wdog_pkg::axil_resp_e  m_axil_bresp_i,
   input  wire logic                  m_axil_bvalid_i,
   output logic                       m_axil_bready_o
  );

  logic tag_toggle_lo;
  logic tag_data_lo;
  logic core_reset_lo;
  logic kick_v_lo;
  logic kick_ready_lo;

  // Frame decode in the tag clock domain
  tag_serial_rx
    #(.tag_node_id_p(tag_node_id_p))
  u_tag_serial_rx
    (.tag_clk_i    (tag_clk_i),
     .arst_n_i     (arst_n_i),
     .tag_data_i   (tag_data_i),
     .tag_toggle_o (tag_toggle_lo),
     .tag_data_o   (tag_data_lo)
    );

  // Core reset level in clk_i
  tag_client_sync u_tag_client_sync
    (.clk_i        (clk_i),
     .arst_n_i     (arst_n_i),
     .tag_toggle_i (tag_toggle_lo),
     .tag_data_i   (tag_data_lo),
     .core_reset_o (core_reset_lo)
    );

  kick_timer
    #(.watchdog_period_p(watchdog_period_p))
  u_kick_timer
    (.clk_i        (clk_i),
     .arst_n_i     (arst_n_i),
     .clear_i      (core_reset_lo),
     .kick_v_o     (kick_v_lo),
     .kick_ready_i (kick_ready_lo)
    );

  // Both timer and writer sit idle while core reset is held
  axil_kick_writer
    #(.kick_addr_p(kick_addr_p),
      .kick_data_p(kick_data_p)
    )
  u_axil_kick_writer
    (.clk_i            (clk_i),
     .arst_n_i         (arst_n_i),
     .clear_i          (core_reset_lo),
     .kick_v_i         (kick_v_lo),
     .kick_ready_o     (kick_ready_lo),
     .m_axil_aw_o      (m_axil_aw_o),
     .m_axil_awvalid_o (m_axil_awvalid_o),
     .m_axil_awready_i (m_axil_awready_i),
     .m_axil_w_o       (m_axil_w_o),
     .m_axil_wvalid_o  (m_axil_wvalid_o),
     .m_axil_wready_i  (m_axil_wready_i),
     .m_axil_bresp_i   (m_axil_bresp_i),
     .m_axil_bvalid_i  (m_axil_bvalid_i),
     .m_axil_bready_o  (m_axil_bready_o)
    );

endmodule

`default_nettype wire

//--- test/axil_slave_model.sv
`default_nettype none

module axil_slave_model
  #(parameter logic [31:0] seed_p = 32'h0000_0001)
  (input  wire logic            clk_i,
   input  wire logic            arst_n_i,
   input  wire logic            awvalid_i,
   output logic                 awready_o,
   input  wire logic            wvalid_i,
   output logic                 wready_o,
   output wdog_pkg::axil_resp_e bresp_o,
   output logic                 bvalid_o,
   input  wire logic            bready_i
  );

  import wdog_pkg::*;

  logic [31:0] lfsr_r;
  logic [3:0]  aw_wait;
  logic [3:0]  w_wait;
  logic [3:0]  b_wait;
  logic [3:0]  pick;
  logic        aw_armed;
  logic        w_armed;
  logic        b_armed;
  logic        aw_got;
  logic        w_got;
  logic        aw_hs = 1'b0;
  logic        w_hs = 1'b0;
  logic        b_hs = 1'b0;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    else
      return state >> 1;
  endfunction

  // One step per bit taken
  task automatic take_bits(input int count, output logic [3:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      value  = {value[2:0], lfsr_r[0]};
    end
  endtask

  initial
  begin
    lfsr_r    = seed_p;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = okay;
  end

  // Handshakes seen at the rising edge
  always @(posedge clk_i)
  begin
    aw_hs = awvalid_i & awready_o;
    w_hs  = wvalid_i & wready_o;
    b_hs  = bvalid_o & bready_i;
  end

  always @(negedge clk_i)
  begin
    if (!arst_n_i)
    begin
      {awready_o, wready_o, bvalid_o} = 3'b000;
      {aw_armed, w_armed, b_armed, aw_got, w_got} = 5'b00000;
    end
    else
    begin
      aw_got = aw_got | aw_hs;
      w_got  = w_got | w_hs;
      // A fresh AW means the master dropped any earlier write
      if (b_hs || (awvalid_i && !aw_armed))
      begin
        {bvalid_o, b_armed, aw_got, w_got} = 4'b0000;
      end
      if (!awvalid_i)
        {awready_o, aw_armed} = 2'b00;
      else if (!awready_o)
      begin
        if (!aw_armed)
          take_bits(2, aw_wait);
        aw_armed = 1'b1;
        if (aw_wait == 0)
          awready_o = 1'b1;
        else
          aw_wait = aw_wait - 1;
      end
      if (!wvalid_i)
        {wready_o, w_armed} = 2'b00;
      else if (!wready_o)
      begin
        if (!w_armed)
          take_bits(2, w_wait);
        w_armed = 1'b1;
        if (w_wait == 0)
          wready_o = 1'b1;
        else
          w_wait = w_wait - 1;
      end
      // Response once both halves of the write are in
      if (aw_got && w_got && !bvalid_o)
      begin
        if (!b_armed)
          take_bits(2, b_wait);
        b_armed = 1'b1;
        if (b_wait == 0)
        begin
          take_bits(1, pick);
          bresp_o  = pick[0] ? slverr : okay;
          bvalid_o = 1'b1;
        end
        else
          b_wait = b_wait - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_axil_watchdog.sv
`default_nettype none

module tb_axil_watchdog;

  import wdog_pkg::*;

  localparam int          period_lp    = 40;
  localparam logic [31:0] kick_addr_lp = 32'h0010_3000;
  localparam logic [31:0] kick_data_lp = 32'h0000_0001;
  localparam logic [3:0]  node_id_lp   = 4'd5;
  // Frame end to visible effect in clk cycles
  localparam int settle_cycles_lp  = 8;
  localparam int timeout_cycles_lp = 6 * 8 * period_lp + 200;

  logic       clk = 1'b0;
  logic       tag_clk = 1'b0;
  logic       arst_n;
  logic       tag_data;
  axil_aw_s   aw;
  logic       awvalid;
  logic       awready;
  axil_w_s    w;
  logic       wvalid;
  logic       wready;
  axil_resp_e bresp;
  logic       bvalid;
  logic       bready;

  string    test_name = "reset_values";
  int       cyc = 0;
  int       aw_count = 0;
  int       b_count = 0;
  int       last_rise = -1;
  int       release_cyc = 0;
  int       exp_gap;
  logic     awvalid_prev = 1'b0;
  logic     halted = 1'b0;
  logic     release_pending = 1'b0;
  axil_aw_s exp_aw;
  axil_w_s  exp_w;

  always #10 clk = ~clk;
  always #15 tag_clk = ~tag_clk;

  axil_watchdog
    #(.watchdog_period_p(period_lp),
      .kick_addr_p(kick_addr_lp),
      .kick_data_p(kick_data_lp),
      .tag_node_id_p(node_id_lp)
    )
  u_axil_watchdog
    (.clk_i(clk), .arst_n_i(arst_n), .tag_clk_i(tag_clk), .tag_data_i(tag_data),
     .m_axil_aw_o(aw), .m_axil_awvalid_o(awvalid), .m_axil_awready_i(awready),
     .m_axil_w_o(w), .m_axil_wvalid_o(wvalid), .m_axil_wready_i(wready),
     .m_axil_bresp_i(bresp), .m_axil_bvalid_i(bvalid), .m_axil_bready_o(bready)
    );

  axil_slave_model
    #(.seed_p(32'h0cad_805b))
  u_axil_slave_model
    (.clk_i(clk), .arst_n_i(arst_n), .awvalid_i(awvalid), .awready_o(awready),
     .wvalid_i(wvalid), .wready_o(wready), .bresp_o(bresp), .bvalid_o(bvalid),
     .bready_i(bready)
    );

  // Fixed kick word, full strobes, one write per period
  function automatic void expected_kick(input int period, output axil_aw_s exp_a,
                                        output axil_w_s exp_d, output int gap);
    exp_a.addr = kick_addr_lp;
    exp_a.prot = 3'b000;
    exp_d.data = kick_data_lp;
    exp_d.strb = 4'hf;
    gap        = period;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_aw(input string name, input axil_aw_s exp, input axil_aw_s act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: aw expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_w(input string name, input axil_w_s exp, input axil_w_s act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: w expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_interval(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("CHECK FAILED %s: interval expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("CHECK FAILED %s: count expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: level expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Start bit, node id MSB first, data bit, then idle
  task automatic send_frame(input logic [3:0] node, input logic value);
    tag_frame_s frame;
    frame.node_id = node;
    frame.data    = value;
    for (int i = $bits(tag_frame_s); i >= 0; i--)
    begin
      @(negedge tag_clk);
      tag_data = (i == $bits(tag_frame_s)) ? 1'b1 : frame[i];
    end
    @(negedge tag_clk);
    tag_data = 1'b0;
  endtask

  task automatic wait_writes(input int count);
    int target;
    target = b_count + count;
    wait (b_count >= target);
  endtask

  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (arst_n)
    begin
      expected_kick(period_lp, exp_aw, exp_w, exp_gap);
      if (halted)
        check_level(test_name, 1'b0, awvalid);
      if (awvalid && !awvalid_prev)
      begin
        if (release_pending)
          check_level(test_name, 1'b1, (cyc - release_cyc) <= settle_cycles_lp);
        else if (last_rise >= 0)
          check_interval(test_name, exp_gap, cyc - last_rise);
        release_pending = 1'b0;
        last_rise       = cyc;
      end
      if (awvalid && awready)
      begin
        // Previous write fully answered before a new address
        check_count("outstanding", aw_count, b_count);
        check_aw(test_name, exp_aw, aw);
        aw_count = aw_count + 1;
      end
      if (wvalid && wready)
        check_w(test_name, exp_w, w);
      if (bvalid && bready)
        b_count = b_count + 1;
      awvalid_prev = awvalid;
    end
  end

  initial
  begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles_lp);
    abort_run();
  end

  initial
  begin
    arst_n   = 1'b0;
    tag_data = 1'b0;
    repeat (8) @(negedge clk);
    check_level("reset_awvalid", 1'b0, awvalid);
    check_level("reset_wvalid", 1'b0, wvalid);
    check_level("reset_bready", 1'b0, bready);
    arst_n    = 1'b1;
    test_name = "cadence";
    wait_writes(6);
    @(negedge clk);
    test_name = "hold";
    send_frame(node_id_lp, 1'b1);
    repeat (settle_cycles_lp) @(negedge clk);
    halted = 1'b1;
    repeat (3 * period_lp) @(negedge clk);
    halted    = 1'b0;
    test_name = "release";
    send_frame(node_id_lp, 1'b0);
    @(negedge clk);
    release_cyc     = cyc;
    release_pending = 1'b1;
    wait_writes(4);
    @(negedge clk);
    test_name = "foreign_node";
    send_frame(4'd3, 1'b1);
    wait_writes(4);
    @(negedge clk);
    check_count("b_vs_aw", aw_count, b_count);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
logic/wdog_pkg.sv
logic/tag_serial_rx.sv
logic/tag_client_sync.sv
logic/kick_timer.sv
logic/axil_kick_writer.sv
logic/axil_watchdog.sv
test/axil_slave_model.sv
test/tb_axil_watchdog.sv
